// ==== include/pitaya_cfg.svh ====
`ifndef PITAYA_CFG_SVH
`define PITAYA_CFG_SVH

//////////////////////////////
// System bus geometry
//////////////////////////////

// Byte address seen by the host
`define PITAYA_ADDR_W 18
// Read and write data
`define PITAYA_DATA_W 32
// Regions carved from the top address bits
`define PITAYA_REGION_N 16
`define PITAYA_REGION_W 4

// Region map, anything else is answered by the decoder
`define PITAYA_REGION_CTS 4
`define PITAYA_REGION_PDM 5

//////////////////////////////
// Peripherals
//////////////////////////////

// Analog PDM outputs
`define PITAYA_PDM_CHN 4
`define PITAYA_PDM_DW 8
// Current time stamp
`define PITAYA_CTS_W 64

`endif

// ==== hdl/pitaya_pkg.sv ====
`default_nettype none

`include "pitaya_cfg.svh"

package pitaya_pkg;

  //////////////////////////////
  // System bus
  //////////////////////////////

  // Transfer direction
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // Command held stable while req is high
  typedef struct packed {
    bus_op_e                   op;
    logic [`PITAYA_ADDR_W-1:0] addr;
    logic [`PITAYA_DATA_W-1:0] wdata;
  } sys_req_t;

  // Response, valid while ack is high
  typedef struct packed {
    logic [`PITAYA_DATA_W-1:0] rdata;
  } sys_rsp_t;

  // Decoder handshake states
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_SLAVE    = 2'd1,
    ST_HOST_ACK = 2'd2,
    ST_RELEASE  = 2'd3
  } dec_state_e;

  //////////////////////////////
  // PDM
  //////////////////////////////

  typedef logic [`PITAYA_PDM_DW-1:0] pdm_level_t;
  typedef pdm_level_t [`PITAYA_PDM_CHN-1:0] pdm_levels_t;

endpackage

`default_nettype wire

// ==== hdl/sys_bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pitaya_cfg.svh"

module sys_bus_decoder
  import pitaya_pkg::*;
(
  input  wire logic                          adc_clk,
  input  wire logic                          top_rst,
  // Host side
  input  wire logic                          host_req_i,
  input  wire sys_req_t                      host_cmd_i,
  output logic                               host_ack_o,
  output sys_rsp_t                           host_rsp_o,
  // Slave side, one req/ack pair per region
  output logic     [`PITAYA_REGION_N-1:0]    slv_req_o,
  output sys_req_t                           slv_cmd_o,
  input  wire logic [`PITAYA_REGION_N-1:0]   slv_ack_i,
  input  wire sys_rsp_t [`PITAYA_REGION_N-1:0] slv_rsp_i
);

  //////////////////////////////
  // Region table
  //////////////////////////////

  localparam logic [`PITAYA_REGION_N-1:0] REGION_ONE = {{(`PITAYA_REGION_N-1){1'b0}}, 1'b1};
  // Regions that have a slave behind them
  localparam logic [`PITAYA_REGION_N-1:0] REGION_MAP =
    (REGION_ONE << `PITAYA_REGION_CTS) | (REGION_ONE << `PITAYA_REGION_PDM);

  dec_state_e                   state_q;
  logic [`PITAYA_REGION_W-1:0]  host_region;
  logic [`PITAYA_REGION_W-1:0]  cmd_region;
  logic                         host_mapped;
  logic                         cmd_mapped;
  logic                         slv_ack_sel;
  logic                         accept;

  // Region comes from the top address bits
  assign host_region = host_cmd_i.addr[`PITAYA_ADDR_W-1 -: `PITAYA_REGION_W];
  assign cmd_region  = slv_cmd_o.addr[`PITAYA_ADDR_W-1 -: `PITAYA_REGION_W];
  assign host_mapped = REGION_MAP[host_region];
  assign cmd_mapped  = REGION_MAP[cmd_region];

  // Ack of the slave addressed by the held command
  assign slv_ack_sel = slv_ack_i[cmd_region];

  // New host request picked up
  assign accept = (state_q == ST_IDLE) && host_req_i;

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state_q    <= ST_IDLE;
      host_ack_o <= 1'b0;
      slv_req_o  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (host_req_i) begin
            if (host_mapped) begin
              // Forward to the selected slave
              slv_req_o <= REGION_ONE << host_region;
              state_q   <= ST_SLAVE;
            end else begin
              // No slave here, answer directly
              host_ack_o <= 1'b1;
              state_q    <= ST_HOST_ACK;
            end
          end
        end
        ST_SLAVE: begin
          if (slv_ack_sel) begin
            host_ack_o <= 1'b1;
            state_q    <= ST_HOST_ACK;
          end
        end
        ST_HOST_ACK: begin
          // Held here until the host lets go
          if (!host_req_i) begin
            slv_req_o <= '0;
            if (cmd_mapped) begin
              state_q <= ST_RELEASE;
            end else begin
              host_ack_o <= 1'b0;
              state_q    <= ST_IDLE;
            end
          end
        end
        ST_RELEASE: begin
          // Wait for the slave to finish its half
          if (!slv_ack_sel) begin
            host_ack_o <= 1'b0;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Command and response
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    // Command stays put for the whole exchange
    if (accept) begin
      slv_cmd_o <= host_cmd_i;
    end
    // Unmapped reads return zero
    if (accept && !host_mapped) begin
      host_rsp_o <= '0;
    end else if ((state_q == ST_SLAVE) && slv_ack_sel) begin
      host_rsp_o <= slv_rsp_i[cmd_region];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cts_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pitaya_cfg.svh"

module cts_counter
  import pitaya_pkg::*;
(
  input  wire logic     adc_clk,
  input  wire logic     top_rst,
  // Slave port
  input  wire logic     bus_req_i,
  input  wire sys_req_t bus_cmd_i,
  output logic          bus_ack_o,
  output sys_rsp_t      bus_rsp_o
);

  // Byte offset inside the region
  localparam int unsigned OFS_W = `PITAYA_ADDR_W - `PITAYA_REGION_W;
  localparam logic [OFS_W-1:0] OFS_LOW  = OFS_W'(0);
  localparam logic [OFS_W-1:0] OFS_HIGH = OFS_W'(4);

  logic [`PITAYA_CTS_W-1:0]  cts_q;
  logic [`PITAYA_DATA_W-1:0] snap_q;
  logic [OFS_W-1:0]          offset;
  logic                      start;
  logic                      rd_low;
  logic                      rd_high;
  sys_rsp_t                  rsp_next;

  assign offset = bus_cmd_i.addr[OFS_W-1:0];

  // First cycle of a request, ack not yet up
  assign start = bus_req_i && !bus_ack_o;

  assign rd_low  = (bus_cmd_i.op == BUS_READ) && (offset == OFS_LOW);
  assign rd_high = (bus_cmd_i.op == BUS_READ) && (offset == OFS_HIGH);

  //////////////////////////////
  // Free-running time stamp
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cts_q <= '0;
    end else begin
      cts_q <= cts_q + 1'b1;
    end
  end

  //////////////////////////////
  // Bus access
  //////////////////////////////

  // Ack follows req by one cycle
  // Low word read freezes the high word of the same count
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus_ack_o <= 1'b0;
      snap_q    <= '0;
    end else begin
      bus_ack_o <= bus_req_i;
      if (start && rd_low) begin
        snap_q <= cts_q[`PITAYA_CTS_W-1 -: `PITAYA_DATA_W];
      end
    end
  end

  // Read mux, writes read back zero
  always_comb begin
    rsp_next = '0;
    if (rd_low) begin
      rsp_next.rdata = cts_q[`PITAYA_DATA_W-1:0];
    end else if (rd_high) begin
      rsp_next.rdata = snap_q;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (start) begin
      bus_rsp_o <= rsp_next;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pdm_regset.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pitaya_cfg.svh"

module pdm_regset
  import pitaya_pkg::*;
(
  input  wire logic     adc_clk,
  input  wire logic     top_rst,
  // Slave port
  input  wire logic     bus_req_i,
  input  wire sys_req_t bus_cmd_i,
  output logic          bus_ack_o,
  output sys_rsp_t      bus_rsp_o,
  // Levels toward the modulators
  output pdm_levels_t   levels_o
);

  localparam int unsigned OFS_W = `PITAYA_ADDR_W - `PITAYA_REGION_W;
  localparam int unsigned IDX_W = $clog2(`PITAYA_PDM_CHN);

  logic [OFS_W-1:0] offset;
  logic [IDX_W-1:0] idx;
  logic             hit;
  logic             start;
  sys_rsp_t         rsp_next;

  assign offset = bus_cmd_i.addr[OFS_W-1:0];

  // One word per channel at 0, 4, 8, 12
  assign idx = offset[2 +: IDX_W];
  assign hit = (offset[OFS_W-1:2] < `PITAYA_PDM_CHN) && (offset[1:0] == 2'b00);

  // Request seen, ack rises on this edge
  assign start = bus_req_i && !bus_ack_o;

  //////////////////////////////
  // Level registers
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus_ack_o <= 1'b0;
      levels_o  <= '0;
    end else begin
      bus_ack_o <= bus_req_i;
      // Write lands together with ack
      if (start && hit && (bus_cmd_i.op == BUS_WRITE)) begin
        levels_o[idx] <= bus_cmd_i.wdata[`PITAYA_PDM_DW-1:0];
      end
    end
  end

  //////////////////////////////
  // Readback
  //////////////////////////////

  // Zero-extended level, zero elsewhere
  always_comb begin
    rsp_next = '0;
    if (hit && (bus_cmd_i.op == BUS_READ)) begin
      rsp_next.rdata = {{(`PITAYA_DATA_W-`PITAYA_PDM_DW){1'b0}}, levels_o[idx]};
    end
  end

  always_ff @(posedge adc_clk) begin
    if (start) begin
      bus_rsp_o <= rsp_next;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pdm_modulator.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pitaya_cfg.svh"

module pdm_modulator
  import pitaya_pkg::*;
(
  input  wire logic                        adc_clk,
  input  wire logic                        top_rst,
  // Density per channel, 0 to 255 of 256
  input  wire pdm_levels_t                 levels_i,
  // 1-bit analog outputs
  output logic [`PITAYA_PDM_CHN-1:0]       pdm_o
);

  //////////////////////////////
  // First-order sigma-delta
  //////////////////////////////

  for (genvar ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin : g_chn

    // Running remainder of the channel
    pdm_level_t               acc_q;
    // Carry sits in the top bit
    logic [`PITAYA_PDM_DW:0]  sum;
    logic                     bit_q;

    assign sum = {1'b0, acc_q} + {1'b0, levels_i[ch]};

    // Wraps every 256 cycles for a fixed level,
    // carry fires exactly level times per wrap
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc_q <= '0;
        bit_q <= 1'b0;
      end else begin
        acc_q <= sum[`PITAYA_PDM_DW-1:0];
        bit_q <= sum[`PITAYA_PDM_DW];
      end
    end

    // Registered carry straight to the pin
    assign pdm_o[ch] = bit_q;

  end

endmodule

`default_nettype wire

// ==== hdl/pitaya_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pitaya_cfg.svh"

module pitaya_core_top
  import pitaya_pkg::*;
(
  input  wire logic                     adc_clk,
  input  wire logic                     top_rst,
  // Host bus
  input  wire logic                     host_req_i,
  input  wire sys_req_t                 host_cmd_i,
  output logic                          host_ack_o,
  output sys_rsp_t                      host_rsp_o,
  // PDM analog outputs
  output logic [`PITAYA_PDM_CHN-1:0]    dac_pdm_o
);

  //////////////////////////////
  // Region wiring
  //////////////////////////////

  logic     [`PITAYA_REGION_N-1:0] slv_req;
  sys_req_t                        slv_cmd;
  logic     [`PITAYA_REGION_N-1:0] slv_ack;
  sys_rsp_t [`PITAYA_REGION_N-1:0] slv_rsp;
  pdm_levels_t                     pdm_levels;

  // Regions without a slave stay quiet
  for (genvar r = 0; r < `PITAYA_REGION_N; r++) begin : g_unused
    if ((r != `PITAYA_REGION_CTS) && (r != `PITAYA_REGION_PDM)) begin : g_tie
      assign slv_ack[r] = 1'b0;
      assign slv_rsp[r] = '0;
    end
  end

  //////////////////////////////
  // Bus decoder
  //////////////////////////////

  sys_bus_decoder u_decoder (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .host_req_i (host_req_i),
    .host_cmd_i (host_cmd_i),
    .host_ack_o (host_ack_o),
    .host_rsp_o (host_rsp_o),
    .slv_req_o  (slv_req),
    .slv_cmd_o  (slv_cmd),
    .slv_ack_i  (slv_ack),
    .slv_rsp_i  (slv_rsp)
  );

  //////////////////////////////
  // Time stamp and PDM
  //////////////////////////////

  cts_counter u_cts (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus_req_i (slv_req[`PITAYA_REGION_CTS]),
    .bus_cmd_i (slv_cmd),
    .bus_ack_o (slv_ack[`PITAYA_REGION_CTS]),
    .bus_rsp_o (slv_rsp[`PITAYA_REGION_CTS])
  );

  pdm_regset u_pdm_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus_req_i (slv_req[`PITAYA_REGION_PDM]),
    .bus_cmd_i (slv_cmd),
    .bus_ack_o (slv_ack[`PITAYA_REGION_PDM]),
    .bus_rsp_o (slv_rsp[`PITAYA_REGION_PDM]),
    .levels_o  (pdm_levels)
  );

  // Full-scale range, always running
  pdm_modulator u_pdm (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .levels_i (pdm_levels),
    .pdm_o    (dac_pdm_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_pitaya_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pitaya_cfg.svh"

module tb_pitaya_core
  import pitaya_pkg::*;
();

  localparam int unsigned OFS_W = `PITAYA_ADDR_W - `PITAYA_REGION_W;
  // Cycle budget per data line, plus reset and setup
  localparam int unsigned LINE_CYCLES = 300;
  localparam int unsigned BASE_CYCLES = 2000;
  // Largest time stamp advance allowed per transaction
  localparam int unsigned CTS_STEP = 20;

  logic                       adc_clk;
  logic                       top_rst;
  logic                       host_req_i;
  sys_req_t                   host_cmd_i;
  logic                       host_ack_o;
  sys_rsp_t                   host_rsp_o;
  logic [`PITAYA_PDM_CHN-1:0] dac_pdm_o;

  // Test table with one entry per data line
  string       t_name[$];
  string       t_op[$];
  string       t_addr[$];
  string       t_wdata[$];
  string       t_exp[$];
  bit          loaded;
  logic [31:0] rng_state;
  // Levels the PDM block should hold
  pdm_levels_t shadow;
  int unsigned xfer_count;

  pitaya_core_top u_dut (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .host_req_i (host_req_i),
    .host_cmd_i (host_cmd_i),
    .host_ack_o (host_ack_o),
    .host_rsp_o (host_rsp_o),
    .dac_pdm_o  (dac_pdm_o)
  );

  // 4 ns period
  initial begin
    adc_clk = 1'b0;
    forever begin
      #2 adc_clk = ~adc_clk;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [`PITAYA_ADDR_W-1:0] region_base(input int unsigned region);
    return `PITAYA_ADDR_W'(region) << OFS_W;
  endfunction

  // Only aligned words 0 to 12 of the PDM region hold a level
  function automatic void update_shadow(input logic [`PITAYA_ADDR_W-1:0] addr,
                                        input logic [`PITAYA_DATA_W-1:0] wdata);
    if ((addr[`PITAYA_ADDR_W-1 -: `PITAYA_REGION_W] == `PITAYA_REGION_PDM) &&
        (addr[OFS_W-1:4] == '0) && (addr[1:0] == 2'b00)) begin
      shadow[addr[3:2]] = wdata[`PITAYA_PDM_DW-1:0];
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_rsp(input string name, input sys_rsp_t exp, input sys_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %08h actual %08h", name, exp.rdata, act.rdata));
    end
  endtask

  task automatic check_level(input string name, input pdm_level_t exp, input pdm_level_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Time stamp must land inside [lo, hi]
  task automatic check_cts(input string name, input logic [`PITAYA_CTS_W-1:0] lo,
                           input logic [`PITAYA_CTS_W-1:0] hi,
                           input logic [`PITAYA_CTS_W-1:0] act);
    if ((act < lo) || (act > hi)) begin
      abort_run($sformatf("mismatch %s expected %0d..%0d actual %0d", name, lo, hi, act));
    end
  endtask

  //////////////////////////////
  // Data file
  //////////////////////////////

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string f_name;
    string f_op;
    string f_addr;
    string f_wdata;
    string f_exp;
    fd = $fopen("sim/pitaya_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the test data file sim/pitaya_testdata.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%s %s %s %s %s", f_name, f_op, f_addr, f_wdata, f_exp);
      // Skip comments and short lines
      if ((n == 5) && (f_name.getc(0) != "#")) begin
        t_name.push_back(f_name);
        t_op.push_back(f_op);
        t_addr.push_back(f_addr);
        t_wdata.push_back(f_wdata);
        t_exp.push_back(f_exp);
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Bus driver
  //////////////////////////////

  // One four-phase exchange with inputs changed on the falling edge
  task automatic bus_xfer(input bus_op_e op, input logic [`PITAYA_ADDR_W-1:0] addr,
                          input logic [`PITAYA_DATA_W-1:0] wdata, output sys_rsp_t rsp);
    @(negedge adc_clk);
    host_cmd_i.op    = op;
    host_cmd_i.addr  = addr;
    host_cmd_i.wdata = wdata;
    host_req_i       = 1'b1;
    do begin
      @(negedge adc_clk);
    end while (!host_ack_o);
    rsp        = host_rsp_o;
    host_req_i = 1'b0;
    // Next request only once ack is back low
    while (host_ack_o) begin
      @(negedge adc_clk);
    end
    xfer_count++;
  endtask

  // Low word first since it freezes the high word
  task automatic read_cts(output logic [`PITAYA_CTS_W-1:0] ts);
    sys_rsp_t lo;
    sys_rsp_t hi;
    bus_xfer(BUS_READ, region_base(`PITAYA_REGION_CTS), '0, lo);
    bus_xfer(BUS_READ, region_base(`PITAYA_REGION_CTS) + 4, '0, hi);
    ts = {hi.rdata, lo.rdata};
  endtask

  // Count high cycles per channel over one full accumulator wrap
  task automatic measure_density(input string name);
    int unsigned high_cnt [`PITAYA_PDM_CHN];
    for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
      high_cnt[ch] = 0;
    end
    repeat (4) @(negedge adc_clk);
    repeat (256) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
        high_cnt[ch] += dac_pdm_o[ch];
      end
    end
    for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
      if (high_cnt[ch] > 255) begin
        abort_run($sformatf("%s channel %0d stayed high for all 256 cycles", name, ch));
      end
      check_level($sformatf("%s_ch%0d", name, ch), shadow[ch], pdm_level_t'(high_cnt[ch]));
    end
  endtask

  // Every region without a slave answers zero and swallows writes
  task automatic sweep_unmapped_regions();
    sys_rsp_t rsp;
    sys_rsp_t exp_rsp;
    for (int r = 0; r < `PITAYA_REGION_N; r++) begin
      if ((r != `PITAYA_REGION_CTS) && (r != `PITAYA_REGION_PDM)) begin
        bus_xfer(BUS_WRITE, region_base(r) + 4 * (r % `PITAYA_PDM_CHN), '1, rsp);
        // Live counter word leaves a nonzero response on the bus
        bus_xfer(BUS_READ, region_base(`PITAYA_REGION_CTS), '0, rsp);
        bus_xfer(BUS_READ, region_base(r), '0, rsp);
        check_rsp($sformatf("unmapped_r%0d", r), '0, rsp);
      end
    end
    // Levels untouched by the writes above
    for (int ch = 0; ch < `PITAYA_PDM_CHN; ch++) begin
      bus_xfer(BUS_READ, region_base(`PITAYA_REGION_PDM) + 4 * ch, '0, rsp);
      exp_rsp.rdata = {{(`PITAYA_DATA_W-`PITAYA_PDM_DW){1'b0}}, shadow[ch]};
      check_rsp($sformatf("level_keep_ch%0d", ch), exp_rsp, rsp);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    string                      name;
    logic [`PITAYA_ADDR_W-1:0]  addr;
    logic [`PITAYA_DATA_W-1:0]  wdata;
    logic [`PITAYA_DATA_W-1:0]  exp_word;
    sys_rsp_t                   rsp;
    sys_rsp_t                   exp_rsp;
    logic [`PITAYA_CTS_W-1:0]   ts_a;
    logic [`PITAYA_CTS_W-1:0]   ts_b;
    int unsigned                xfer_before;
    top_rst    = 1'b1;
    host_req_i = 1'b0;
    host_cmd_i = '0;
    rng_state  = 32'd69;
    shadow     = '0;
    xfer_count = 0;
    load_tests();
    loaded = 1'b1;
    repeat (16) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;
    @(negedge adc_clk);
    if ((host_ack_o !== 1'b0) || (dac_pdm_o !== '0)) begin
      abort_run($sformatf("mismatch reset_state expected ack 0 pdm 0 actual ack %b pdm %b",
                          host_ack_o, dac_pdm_o));
    end
    for (int i = 0; i < t_name.size(); i++) begin
      name = t_name[i];
      void'($sscanf(t_addr[i], "%h", addr));
      if (t_wdata[i] == "random") begin
        rng_state = next_random(rng_state);
        wdata     = rng_state;
      end else begin
        void'($sscanf(t_wdata[i], "%h", wdata));
      end
      if (t_op[i] == "wr") begin
        bus_xfer(BUS_WRITE, addr, wdata, rsp);
        update_shadow(addr, wdata);
      end else if (t_op[i] == "rd") begin
        bus_xfer(BUS_READ, addr, '0, rsp);
        // level means the channel value the host last wrote
        if (t_exp[i] == "level") begin
          exp_word = {{(`PITAYA_DATA_W-`PITAYA_PDM_DW){1'b0}}, shadow[addr[3:2]]};
        end else begin
          void'($sscanf(t_exp[i], "%h", exp_word));
        end
        exp_rsp.rdata = exp_word;
        check_rsp(name, exp_rsp, rsp);
      end else if (t_op[i] == "pdm") begin
        measure_density(name);
      end else if (t_op[i] == "cts") begin
        read_cts(ts_a);
        xfer_before = xfer_count;
        bus_xfer(BUS_WRITE, addr, wdata, rsp);
        read_cts(ts_b);
        // High read, write and low read sit between the two samples
        check_cts(name, ts_a + 1, ts_a + CTS_STEP * (xfer_count - xfer_before), ts_b);
      end else begin
        abort_run($sformatf("test %s has an unknown operation %s", name, t_op[i]));
      end
    end
    sweep_unmapped_regions();
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog budget scales with the data file
  initial begin
    int unsigned limit;
    wait (loaded);
    limit = t_name.size() * LINE_CYCLES + BASE_CYCLES;
    repeat (limit) @(posedge adc_clk);
    abort_run($sformatf("timeout, the run did not finish within %0d cycles", limit));
  end

endmodule

`default_nettype wire

// ==== sim/pitaya_testdata.txt ====
# name op addr wdata expected, addr/wdata/expected in hex
# op wr/rd/pdm/cts, wdata random = xorshift, expected level = last written channel value
rst_lvl0 rd 14000 0 0
rst_lvl1 rd 14004 0 0
rst_lvl2 rd 14008 0 0
rst_lvl3 rd 1400c 0 0
wr_lvl0 wr 14000 000001a5 -
wr_lvl1 wr 14004 random -
wr_lvl2 wr 14008 ffffff00 -
wr_lvl3 wr 1400c 7fffffff -
rd_lvl0 rd 14000 0 a5
rd_lvl1 rd 14004 0 level
rd_lvl2 rd 14008 0 0
rd_lvl3 rd 1400c 0 ff
pdm_mix pdm 0 0 -
wr_pdm_ofs10 wr 14010 ffffffff -
rd_pdm_ofs10 rd 14010 0 0
rd_pdm_far rd 17ffc 0 0
wr_unm0 wr 00000 12345678 -
wr_unm15 wr 3c004 ffffffff -
rd_unm0 rd 00000 0 0
rd_unm3 rd 0c000 0 0
rd_unm6 rd 18000 0 0
rd_unm15 rd 3c004 0 0
rd_lvl0_keep rd 14000 0 a5
rd_lvl3_keep rd 1400c 0 ff
wr_lvl0_full wr 14000 ff -
wr_lvl1_rand wr 14004 random -
wr_lvl2_rand wr 14008 random -
wr_lvl3_zero wr 1400c 00000100 -
pdm_rand pdm 0 0 -
cts_wr_ofs8 cts 10008 deadbeef -
cts_wr_ofs0 cts 10000 ffffffff -
rd_cts_ofs8 rd 10008 0 0
rd_cts_ofsc rd 1000c 0 0

// ==== project.f ====
+incdir+include
hdl/pitaya_pkg.sv
hdl/sys_bus_decoder.sv
hdl/cts_counter.sv
hdl/pdm_regset.sv
hdl/pdm_modulator.sv
hdl/pitaya_core_top.sv
sim/tb_pitaya_core.sv

// ==== Bender.yml ====
package:
  name: pitaya_core

export_include_dirs:
  - include

sources:
  - hdl/pitaya_pkg.sv
  - hdl/sys_bus_decoder.sv
  - hdl/cts_counter.sv
  - hdl/pdm_regset.sv
  - hdl/pdm_modulator.sv
  - hdl/pitaya_core_top.sv
  - target: test
    files:
      - sim/tb_pitaya_core.sv
